// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = sim.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu(
    input                       rst,
    input                       clk,
    input                       cen,
    input  cpu_pkg::alu_req_t   alu_req,
    input                       flag_we,
    output logic        [15:0]  result,
    output cpu_pkg::flags_t     flags
);
    import cpu_pkg::*;

    logic [16:0] wide;
    flags_t      flags_nx;

    always_comb begin
        wide       = {1'b0, alu_req.a};
        flags_nx   = flags;
        case (alu_req.op)
            OP_ADD: begin
                wide       = {1'b0, alu_req.a} + {1'b0, alu_req.b};
                flags_nx.c = wide[16];
                flags_nx.v = (alu_req.a[15] == alu_req.b[15]) &&
                             (wide[15] != alu_req.a[15]);
            end
            OP_SUB: begin
                // carry holds the borrow
                wide       = {1'b0, alu_req.a} - {1'b0, alu_req.b};
                flags_nx.c = wide[16];
                flags_nx.v = (alu_req.a[15] != alu_req.b[15]) &&
                             (wide[15] != alu_req.a[15]);
            end
            OP_AND, OP_OR, OP_XOR: begin
                if (alu_req.op == OP_AND) begin
                    wide[15:0] = alu_req.a & alu_req.b;
                end else if (alu_req.op == OP_OR) begin
                    wide[15:0] = alu_req.a | alu_req.b;
                end else begin
                    wide[15:0] = alu_req.a ^ alu_req.b;
                end
                flags_nx.c = 1'b0;
                flags_nx.v = 1'b0;
            end
            default: begin
                wide = {1'b0, alu_req.a};
            end
        endcase
        result     = wide[15:0];
        flags_nx.s = result[15];
        flags_nx.z = result == 16'd0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (cen && flag_we) begin
            flags <= flags_nx;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        flag_we |-> alu_req.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR})
        else $error("cpu_alu: flag write with op %0d", alu_req.op);

endmodule

// ==== hw/cpu_busctl.sv ====
`timescale 1ns/1ps

module cpu_busctl(
    input                       rst,
    input                       clk,
    input                       cen,
    input  cpu_pkg::mem_req_t   mem_req,
    // external memory
    output logic        [23:0]  addr,
    input               [15:0]  din,
    output logic        [15:0]  dout,
    output logic        [ 1:0]  we,
    // word read back to the core
    output logic        [15:0]  rdata
);

    assign addr = mem_req.addr;
    assign dout = mem_req.wdata;
    // aligned words only, so both lanes together
    assign we   = {2{mem_req.wr}};

    // memory answers combinationally, din is valid at this edge
    always_ff @(posedge clk) begin
        if (cen && mem_req.rd) begin
            rdata <= din;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr))
        else $error("cpu_busctl: read and write requested together");

endmodule

// ==== hw/cpu_ctrl.sv ====
`timescale 1ns/1ps

module cpu_ctrl(
    input                       rst,
    input                       clk,
    input                       cen,
    // bus side
    output cpu_pkg::mem_req_t   mem_req,
    input               [15:0]  rdata,
    input               [23:0]  pc,
    // ALU
    output cpu_pkg::alu_req_t   alu_req,
    output logic                flag_we,
    input               [15:0]  alu_result,
    input  cpu_pkg::flags_t     flags,
    // register bank
    output logic        [ 2:0]  ra_idx,
    output logic        [ 2:0]  rb_idx,
    input               [15:0]  rd_a,
    input               [15:0]  rd_b,
    output cpu_pkg::reg_wr_t    reg_wr,
    // program counter
    output logic                pc_inc,
    output logic                pc_rel,
    output logic        [15:0]  rel_off,
    output logic                halted
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        S_FETCH  = 4'b0001,
        S_EXEC   = 4'b0010,
        S_MEM    = 4'b0100,
        S_HALTED = 4'b1000
    } state_e;

    state_e      state, state_nx;
    instr_t      ir;
    opcode_e     op;
    logic [2:0]  dst;
    logic [15:0] imm_sx;
    logic        ld_pend;
    logic [2:0]  ld_dst;

    // instruction word stays in rdata from the end of FETCH to the end of MEM
    assign ir       = rdata;
    assign op       = ir.rr.op;
    // dst sits in the same bits in both forms
    assign dst      = ir.rr.dst;
    assign imm_sx   = {{7{ir.imm.imm[8]}}, ir.imm.imm};
    assign halted   = state == S_HALTED;

    always_comb begin
        state_nx   = state;
        mem_req    = '0;
        alu_req.op = OP_NOP;
        alu_req.a  = rd_a;
        alu_req.b  = rd_b;
        flag_we    = 1'b0;
        ra_idx     = dst;
        rb_idx     = ir.rr.src;
        reg_wr     = '0;
        pc_inc     = 1'b0;
        pc_rel     = 1'b0;
        rel_off    = imm_sx;
        case (state)
            S_FETCH: begin
                mem_req.rd   = 1'b1;
                mem_req.addr = pc;
                pc_inc       = cen;
                // load data from the previous instruction is written here
                reg_wr.en    = cen & ld_pend;
                reg_wr.idx   = ld_dst;
                reg_wr.data  = rdata;
                state_nx     = S_EXEC;
            end
            S_EXEC: begin
                state_nx = S_FETCH;
                case (op)
                    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                        alu_req.op  = op;
                        flag_we     = cen;
                        reg_wr.en   = cen;
                        reg_wr.idx  = dst;
                        reg_wr.data = alu_result;
                    end
                    OP_CMP: begin
                        // subtract for the flags only
                        alu_req.op = OP_SUB;
                        flag_we    = cen;
                    end
                    OP_ADDI: begin
                        alu_req.op  = OP_ADD;
                        alu_req.b   = imm_sx;
                        flag_we     = cen;
                        reg_wr.en   = cen;
                        reg_wr.idx  = dst;
                        reg_wr.data = alu_result;
                    end
                    OP_LDI: begin
                        reg_wr.en   = cen;
                        reg_wr.idx  = dst;
                        reg_wr.data = imm_sx;
                    end
                    OP_LDH: begin
                        reg_wr.en   = cen;
                        reg_wr.idx  = dst;
                        reg_wr.data = {ir.imm.imm[7:0], rd_a[7:0]};
                    end
                    OP_JRZ: begin
                        pc_rel = cen & flags.z;
                    end
                    OP_LD, OP_ST: begin
                        state_nx = S_MEM;
                    end
                    OP_HALT: begin
                        state_nx = S_HALTED;
                    end
                    default: begin
                        state_nx = S_FETCH;
                    end
                endcase
            end
            S_MEM: begin
                // word address from src and store data from dst
                ra_idx        = ir.rr.src;
                rb_idx        = dst;
                mem_req.addr  = {7'd0, rd_a, 1'b0};
                mem_req.rd    = op == OP_LD;
                mem_req.wr    = op == OP_ST;
                mem_req.wdata = rd_b;
                state_nx      = S_FETCH;
            end
            default: begin
                state_nx = S_HALTED;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_FETCH;
            ld_pend <= 1'b0;
        end else if (cen) begin
            state <= state_nx;
            if (state == S_MEM) begin
                ld_pend <= op == OP_LD;
            end else if (state == S_FETCH) begin
                ld_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && state == S_MEM) begin
            ld_dst <= dst;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        state inside {S_FETCH, S_EXEC, S_MEM, S_HALTED})
        else $error("cpu_ctrl: illegal state %b", state);

endmodule

// ==== hw/cpu_pc.sv ====
`timescale 1ns/1ps

module cpu_pc #(
    parameter logic [23:0] PC_RSTVAL = 24'h000000
)(
    input                   rst,
    input                   clk,
    input                   cen,
    input                   pc_inc,
    input                   pc_rel,
    input           [15:0]  rel_off,
    output logic    [23:0]  pc
);

    logic [23:0] rel_sx;

    // offset counts words
    assign rel_sx = {{7{rel_off[15]}}, rel_off, 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= PC_RSTVAL;
        end else if (cen) begin
            if (pc_rel) begin
                pc <= pc + rel_sx;
            end else if (pc_inc) begin
                pc <= pc + 24'd2;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
        else $error("cpu_pc: odd pc %h", pc);

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // instruction codes, codes 13 and 14 behave as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LDI  = 4'd7,
        OP_LDH  = 4'd8,
        OP_LD   = 4'd9,
        OP_ST   = 4'd10,
        OP_JRZ  = 4'd11,
        OP_CMP  = 4'd12,
        OP_HALT = 4'd15
    } opcode_e;

    // register-register form
    typedef struct packed {
        opcode_e     op;
        logic [2:0]  dst;
        logic [2:0]  src;
        logic [5:0]  unused;
    } rr_fmt_t;

    // immediate form, imm is signed
    typedef struct packed {
        opcode_e            op;
        logic [2:0]         dst;
        logic signed [8:0]  imm;
    } imm_fmt_t;

    // same sixteen bits, two views
    typedef union packed {
        rr_fmt_t   rr;
        imm_fmt_t  imm;
    } instr_t;

    typedef struct packed {
        logic s;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        opcode_e      op;
        logic [15:0]  a;
        logic [15:0]  b;
    } alu_req_t;

    typedef struct packed {
        logic         en;
        logic [2:0]   idx;
        logic [15:0]  data;
    } reg_wr_t;

    typedef struct packed {
        logic         rd;
        logic         wr;
        logic [23:0]  addr;
        logic [15:0]  wdata;
    } mem_req_t;

    // dump map: 0-15 register bytes, 16 flags, 17-19 pc bytes
    localparam logic [7:0] DUMP_FLAGS = 8'd16;

endpackage

// ==== hw/cpu_regs.sv ====
`timescale 1ns/1ps

module cpu_regs(
    input                       rst,
    input                       clk,
    input                       cen,
    input               [ 2:0]  ra_idx,
    input               [ 2:0]  rb_idx,
    output logic        [15:0]  rd_a,
    output logic        [15:0]  rd_b,
    input  cpu_pkg::reg_wr_t    reg_wr,
    // dump port
    input  cpu_pkg::flags_t     flags,
    input               [23:0]  pc,
    input               [ 7:0]  dmp_addr,
    output logic        [ 7:0]  dmp_dout
);
    import cpu_pkg::*;

    logic [15:0] rf [8];
    logic [15:0] dmp_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                rf[i] <= 16'd0;
            end
        end else if (cen && reg_wr.en) begin
            rf[reg_wr.idx] <= reg_wr.data;
        end
    end

    // asynchronous reads
    assign rd_a = rf[ra_idx];
    assign rd_b = rf[rb_idx];

    assign dmp_word = rf[dmp_addr[3:1]];

    always_comb begin
        dmp_dout = 8'd0;
        if (dmp_addr < DUMP_FLAGS) begin
            // odd address picks the high byte
            dmp_dout = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end else begin
            case (dmp_addr)
                DUMP_FLAGS:         dmp_dout = {4'd0, flags};
                DUMP_FLAGS + 8'd1:  dmp_dout = pc[7:0];
                DUMP_FLAGS + 8'd2:  dmp_dout = pc[15:8];
                DUMP_FLAGS + 8'd3:  dmp_dout = pc[23:16];
                default:            dmp_dout = 8'd0;
            endcase
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [23:0] PC_RSTVAL = 24'h000000
)(
    input                   rst,
    input                   clk,
    input                   cen,

    output logic    [23:0]  addr,
    input           [15:0]  din,
    output logic    [15:0]  dout,
    output logic    [ 1:0]  we,

    output logic            halted,
    // register dump
    input           [ 7:0]  dmp_addr,
    output logic    [ 7:0]  dmp_dout
);
    import cpu_pkg::*;

    mem_req_t    mem_req;
    alu_req_t    alu_req;
    reg_wr_t     reg_wr;
    flags_t      flags;
    logic [15:0] rdata, rd_a, rd_b, alu_result, rel_off;
    logic [ 2:0] ra_idx, rb_idx;
    logic [23:0] pc;
    logic        flag_we, pc_inc, pc_rel;

    cpu_ctrl u_ctrl(
        .rst        ( rst           ),
        .clk        ( clk           ),
        .cen        ( cen           ),
        .mem_req    ( mem_req       ),
        .rdata      ( rdata         ),
        .pc         ( pc            ),
        .alu_req    ( alu_req       ),
        .flag_we    ( flag_we       ),
        .alu_result ( alu_result    ),
        .flags      ( flags         ),
        .ra_idx     ( ra_idx        ),
        .rb_idx     ( rb_idx        ),
        .rd_a       ( rd_a          ),
        .rd_b       ( rd_b          ),
        .reg_wr     ( reg_wr        ),
        .pc_inc     ( pc_inc        ),
        .pc_rel     ( pc_rel        ),
        .rel_off    ( rel_off       ),
        .halted     ( halted        )
    );

    cpu_regs u_regs(
        .rst        ( rst           ),
        .clk        ( clk           ),
        .cen        ( cen           ),
        .ra_idx     ( ra_idx        ),
        .rb_idx     ( rb_idx        ),
        .rd_a       ( rd_a          ),
        .rd_b       ( rd_b          ),
        .reg_wr     ( reg_wr        ),
        .flags      ( flags         ),
        .pc         ( pc            ),
        .dmp_addr   ( dmp_addr      ),
        .dmp_dout   ( dmp_dout      )
    );

    cpu_alu u_alu(
        .rst        ( rst           ),
        .clk        ( clk           ),
        .cen        ( cen           ),
        .alu_req    ( alu_req       ),
        .flag_we    ( flag_we       ),
        .result     ( alu_result    ),
        .flags      ( flags         )
    );

    cpu_pc #(.PC_RSTVAL(PC_RSTVAL)) u_pc(
        .rst        ( rst           ),
        .clk        ( clk           ),
        .cen        ( cen           ),
        .pc_inc     ( pc_inc        ),
        .pc_rel     ( pc_rel        ),
        .rel_off    ( rel_off       ),
        .pc         ( pc            )
    );

    cpu_busctl u_busctl(
        .rst        ( rst           ),
        .clk        ( clk           ),
        .cen        ( cen           ),
        .mem_req    ( mem_req       ),
        .addr       ( addr          ),
        .din        ( din           ),
        .dout       ( dout          ),
        .we         ( we            ),
        .rdata      ( rdata         )
    );

endmodule

// ==== sim.f ====
hw/cpu_pkg.sv
hw/cpu_ctrl.sv
hw/cpu_regs.sv
hw/cpu_alu.sv
hw/cpu_pc.sv
hw/cpu_busctl.sv
hw/cpu_top.sv
test/cpu_tb.sv

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam logic [23:0] PC_START   = 24'h000100;
    localparam int          PROG_WORD  = int'(PC_START >> 1);
    localparam int          NUM_TESTS  = 12;
    localparam int          BODY_LEN   = 24;
    // pointer setup plus random body plus HALT
    localparam int          PROG_LEN   = 4 + BODY_LEN + 1;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 3 * PROG_LEN * 8;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [23:0] addr;
    logic [15:0] din;
    logic [15:0] dout;
    logic [ 1:0] we;
    logic        halted;
    logic [ 7:0] dmp_addr;
    logic [ 7:0] dmp_dout;

    bit          cen_on = 1'b0;
    logic [15:0] mem     [0:65535];
    logic [15:0] ref_mem [0:65535];
    logic [15:0] m_regs  [8];
    flags_t      m_flags;
    int          m_steps;
    logic [23:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          errors = 0;
    int          test_errors = 0;
    int          tests_failed = 0;
    int          stores_seen = 0;

    cpu_top #(.PC_RSTVAL(PC_START)) u_cpu_top(
        .rst        ( rst       ),
        .clk        ( clk       ),
        .cen        ( cen       ),
        .addr       ( addr      ),
        .din        ( din       ),
        .dout       ( dout      ),
        .we         ( we        ),
        .halted     ( halted    ),
        .dmp_addr   ( dmp_addr  ),
        .dmp_dout   ( dmp_dout  )
    );

    // combinational memory over the low 128 KB
    assign din = mem[addr[16:1]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // roughly three enabled cycles out of four
    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            cen = cen_on && ($urandom % 4 != 0);
        end
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_store(logic [23:0] a, logic [15:0] d);
        logic [23:0] ea;
        logic [15:0] ed;
        if (exp_addr.size() == 0) begin
            $display("unexpected store of %h to %h at %0t ns", d, a, $time);
            count_error();
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            stores_seen++;
            if (a !== ea || d !== ed) begin
                $display("Fail at %0t ns: store %h to %h, expected %h to %h",
                         $time, d, a, ed, ea);
                count_error();
            end
        end
    endtask

    task automatic check_reg(int idx, logic [15:0] v);
        if (v !== m_regs[idx]) begin
            $display("Fail at %0t ns: r%0d is %h, expected %h", $time, idx, v, m_regs[idx]);
            count_error();
        end
    endtask

    task automatic check_flags(flags_t f);
        if (f !== m_flags) begin
            $display("Fail at %0t ns: flags szcv %b, expected %b", $time, f, m_flags);
            count_error();
        end
    endtask

    task automatic check_pc(logic [23:0] p);
        if (p !== PC_START) begin
            $display("Fail at %0t ns: pc after reset %h, expected %h", $time, p, PC_START);
            count_error();
        end
    endtask

    // stores commit at enabled edges
    always @(posedge clk) begin
        if (!rst && cen && we == 2'b11) begin
            mem[addr[16:1]] = dout;
            if (halted) begin
                $display("store to %h seen after HALT at %0t ns", addr, $time);
                count_error();
            end else begin
                check_store(addr, dout);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the core did not finish the programs in time");
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [15:0] fill_word(int idx);
        logic [15:0] w;
        w = idx[15:0];
        return {w[7:0], w[15:8]} ^ 16'h5ac3;
    endfunction

    function automatic logic [15:0] enc_rr(opcode_e op, logic [2:0] dst, logic [2:0] src);
        instr_t w;
        w.rr.op     = op;
        w.rr.dst    = dst;
        w.rr.src    = src;
        // spare bits must be ignored
        w.rr.unused = 6'($urandom);
        return w;
    endfunction

    function automatic logic [15:0] enc_imm(opcode_e op, logic [2:0] dst, logic [8:0] imm);
        instr_t w;
        w.imm.op  = op;
        w.imm.dst = dst;
        w.imm.imm = imm;
        return w;
    endfunction

    function automatic logic [8:0] small_imm();
        return 9'(int'($urandom % 17) - 8);
    endfunction

    task automatic build_program();
        logic [15:0] prog [$];
        logic [15:0] w;
        logic [2:0]  d;
        logic [2:0]  s;
        logic [2:0]  ptr;
        int          kind;
        int          room;
        for (int i = 0; i < 65536; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = mem[i];
        end
        // r6 and r7 point into the data region at words 0x4000 to 0x41ff
        prog.push_back(enc_imm(OP_LDI, 3'd6, 9'($urandom % 256)));
        prog.push_back(enc_imm(OP_LDH, 3'd6, 9'h040));
        prog.push_back(enc_imm(OP_LDI, 3'd7, 9'($urandom % 256)));
        prog.push_back(enc_imm(OP_LDH, 3'd7, 9'h041));
        for (int j = 0; j < BODY_LEN; j++) begin
            kind = $urandom % 16;
            d    = 3'($urandom % 6);
            s    = 3'($urandom % 8);
            ptr  = 3'(6 + $urandom % 2);
            case (kind)
                0:       w = enc_rr(OP_ADD, d, s);
                1:       w = enc_rr(OP_SUB, d, s);
                2:       w = enc_rr(OP_AND, d, s);
                3:       w = enc_rr(OP_OR, d, s);
                4:       w = enc_rr(OP_XOR, d, s);
                5:       w = enc_rr(OP_CMP, d, s);
                6:       w = enc_imm(OP_ADDI, d, small_imm());
                7:       w = enc_imm(OP_LDI, d, small_imm());
                8:       w = enc_imm(OP_LDI, d, 9'($urandom));
                9:       w = enc_imm(OP_LDH, d, 9'($urandom));
                10, 11:  w = enc_rr(OP_ST, s, ptr);
                12:      w = enc_rr(OP_LD, d, ptr);
                13, 14: begin
                    // forward only and never past the HALT
                    room = BODY_LEN - 1 - j;
                    if (room > 3) begin
                        room = 3;
                    end
                    w = enc_imm(OP_JRZ, 3'($urandom), 9'($urandom % (room + 1)));
                end
                default: begin
                    // NOP and the two spare codes
                    case ($urandom % 3)
                        0:       w = {4'd0, 12'($urandom)};
                        1:       w = {4'd13, 12'($urandom)};
                        default: w = {4'd14, 12'($urandom)};
                    endcase
                end
            endcase
            prog.push_back(w);
        end
        prog.push_back(enc_rr(OP_HALT, 3'd0, 3'd0));
        for (int i = 0; i < prog.size(); i++) begin
            mem[PROG_WORD + i]     = prog[i];
            ref_mem[PROG_WORD + i] = prog[i];
        end
    endtask

    function automatic logic [15:0] add_sub(input logic [15:0] a, input logic [15:0] b,
                                            input bit sub, output flags_t f);
        logic [15:0] r;
        int          ua;
        int          sr;
        if (sub) begin
            r   = a - b;
            f.c = a < b;
            sr  = int'($signed(a)) - int'($signed(b));
        end else begin
            r   = a + b;
            ua  = int'(a) + int'(b);
            f.c = ua > 65535;
            sr  = int'($signed(a)) + int'($signed(b));
        end
        f.v = sr > 32767 || sr < -32768;
        f.s = r[15];
        f.z = r == 16'd0;
        return r;
    endfunction

    function automatic flags_t logic_flags(logic [15:0] r);
        flags_t f;
        f.s = r[15];
        f.z = r == 16'd0;
        f.c = 1'b0;
        f.v = 1'b0;
        return f;
    endfunction

    // reference model running straight from ref_mem
    task automatic run_model();
        logic [23:0] pc;
        instr_t      w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [15:0] imm_sx;
        bit          done;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = 16'd0;
        end
        m_flags = '0;
        exp_addr.delete();
        exp_data.delete();
        pc      = PC_START;
        done    = 1'b0;
        m_steps = 0;
        while (!done && m_steps < PROG_LEN) begin
            w       = ref_mem[pc[16:1]];
            pc      = pc + 24'd2;
            m_steps++;
            a       = m_regs[w.rr.dst];
            b       = m_regs[w.rr.src];
            imm_sx  = 16'($signed(w.imm.imm));
            case (w.rr.op)
                OP_ADD:  m_regs[w.rr.dst] = add_sub(a, b, 1'b0, m_flags);
                OP_SUB:  m_regs[w.rr.dst] = add_sub(a, b, 1'b1, m_flags);
                OP_CMP:  r = add_sub(a, b, 1'b1, m_flags);
                OP_AND, OP_OR, OP_XOR: begin
                    if (w.rr.op == OP_AND) begin
                        r = a & b;
                    end else if (w.rr.op == OP_OR) begin
                        r = a | b;
                    end else begin
                        r = a ^ b;
                    end
                    m_regs[w.rr.dst] = r;
                    m_flags = logic_flags(r);
                end
                OP_ADDI: m_regs[w.imm.dst] = add_sub(a, imm_sx, 1'b0, m_flags);
                OP_LDI:  m_regs[w.imm.dst] = imm_sx;
                OP_LDH:  m_regs[w.imm.dst] = {w.imm.imm[7:0], a[7:0]};
                OP_LD:   m_regs[w.rr.dst] = ref_mem[b];
                OP_ST: begin
                    ref_mem[b] = a;
                    exp_addr.push_back({7'd0, b, 1'b0});
                    exp_data.push_back(a);
                end
                OP_JRZ: begin
                    if (m_flags.z) begin
                        pc = pc + 24'(2 * int'(w.imm.imm));
                    end
                end
                OP_HALT: done = 1'b1;
                default: begin
                end
            endcase
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic read_dump(input logic [7:0] a, output logic [7:0] d);
        @(posedge clk);
        #2;
        dmp_addr = a;
        @(negedge clk);
        d = dmp_dout;
    endtask

    // cen is still low here so nothing has run yet
    task automatic check_after_reset();
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        @(negedge clk);
        if (we !== 2'b00 || halted !== 1'b0) begin
            $display("Fail at %0t ns: we %b halted %b after reset, expected 00 and 0",
                     $time, we, halted);
            count_error();
        end
        read_dump(DUMP_FLAGS + 8'd1, b0);
        read_dump(DUMP_FLAGS + 8'd2, b1);
        read_dump(DUMP_FLAGS + 8'd3, b2);
        check_pc({b2, b1, b0});
    endtask

    task automatic watch_halt();
        repeat (20) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                $display("Fail at %0t ns: halted is %b before any reset, expected 1",
                         $time, halted);
                count_error();
            end
        end
    endtask

    task automatic check_final();
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] fb;
        for (int i = 0; i < 8; i++) begin
            read_dump(8'(2 * i), lo);
            read_dump(8'(2 * i + 1), hi);
            check_reg(i, {hi, lo});
        end
        read_dump(DUMP_FLAGS, fb);
        check_flags(flags_t'(fb[3:0]));
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never reached the bus", exp_addr.size());
            count_error();
        end
    endtask

    initial begin
        void'($urandom(7));
        rst      = 1'b1;
        dmp_addr = 8'd0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            stores_seen = 0;
            build_program();
            run_model();
            reset_dut();
            check_after_reset();
            @(negedge clk);
            cen_on = 1'b1;
            while (halted !== 1'b1) begin
                @(negedge clk);
            end
            watch_halt();
            cen_on = 1'b0;
            check_final();
            if (test_errors != 0) begin
                tests_failed++;
            end
            $display("test %0d: %0d instructions, %0d stores, %0d errors",
                     t, m_steps, stores_seen, test_errors);
        end
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
